// ==== rtl/mem_pkg.sv ====
//////////////////////////////
// Memory subsystem package
// Bus and array widths, access phases, timer steps
//////////////////////////////
`default_nettype none

package mem_pkg;

   //////////////////////////////
   // Bus side types
   //////////////////////////////
   typedef logic [31:0]  bus_word_t;
   typedef logic [15:0]  bus_addr_t;
   typedef logic [2:0]   size_code_t;
   // One-hot: bit 0 icache, bit 1 dcache, bit 2 DMA
   typedef logic [2:0]   dest_t;
   typedef logic [1:0]   beat_idx_t;

   //////////////////////////////
   // Array side types
   //////////////////////////////
   typedef logic [14:0]  mem_addr_t;
   typedef logic [9:0]   row_idx_t;
   // Byte 0 sits in bits 7:0
   typedef logic [127:0] line_t;
   typedef logic [255:0] row_t;
   typedef logic [31:0]  byte_mask_t;

   // Phase of the access stage timer
   typedef enum logic [1:0]
   {
      ACC_IDLE,
      ACC_WAIT,
      ACC_STROBE,
      ACC_DONE
   } access_state_t;

   localparam int BEATS_PER_LINE = 4;

   // Thermometer positions of the memory timer
   localparam int WRITE_STROBE_STEP = 2;
   localparam int READ_SAMPLE_STEP  = 3;
   localparam int DONE_STEP         = 6;

endpackage

`default_nettype wire

// ==== rtl/bus_slave_port.sv ====
//////////////////////////////
// Bus slave port: gathers inbound beats into
// a write line or a single-beat read request
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module bus_slave_port
(
   input  logic                bus_clk,
   input  logic                arst_n,
   input  logic                in_valid,
   output logic                in_ready,
   input  logic                in_write,
   input  mem_pkg::bus_addr_t  in_addr,
   input  mem_pkg::size_code_t in_size,
   input  mem_pkg::dest_t      in_src,
   input  mem_pkg::bus_word_t  in_data,
   output logic                req_valid,
   input  logic                req_ready,
   output logic                req_write,
   output mem_pkg::bus_addr_t  req_addr,
   output mem_pkg::size_code_t req_size,
   output mem_pkg::dest_t      req_src,
   output mem_pkg::line_t      req_line
);
   import mem_pkg::*;

   beat_idx_t beat_cnt;
   logic      beat_acc;
   logic      last_beat;
   logic      req_done;

   // Bus is held off while a finished request waits
   assign in_ready  = ~req_valid;
   assign beat_acc  = in_valid & in_ready;
   assign last_beat = (beat_cnt == beat_idx_t'(BEATS_PER_LINE - 1));
   // Read needs one beat, write needs a full line
   assign req_done  = beat_acc & (~in_write | last_beat);

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         req_valid <= 1'b0;
         beat_cnt  <= '0;
      end
      else
      begin
         if (req_done)
            req_valid <= 1'b1;
         else if (req_valid && req_ready)
            req_valid <= 1'b0;

         // Counter wraps back to zero after the fourth beat
         if (beat_acc && in_write)
            beat_cnt <= beat_cnt + beat_idx_t'(1);
      end
   end

   // Request fields come from the first beat
   always_ff @(posedge bus_clk)
   begin
      if (beat_acc && beat_cnt == '0)
      begin
         req_write <= in_write;
         req_addr  <= in_addr;
         req_size  <= in_size;
         req_src   <= in_src;
      end
      if (beat_acc && in_write)
         req_line[32*beat_cnt +: 32] <= in_data;
   end

endmodule

`default_nettype wire

// ==== rtl/mem_access_ctrl.sv ====
//////////////////////////////
// Access controller: write latch and access
// stages, memory timer and array strobes
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module mem_access_ctrl
(
   input  logic                bus_clk,
   input  logic                arst_n,
   input  logic                req_valid,
   output logic                req_ready,
   input  logic                req_write,
   input  mem_pkg::bus_addr_t  req_addr,
   input  mem_pkg::size_code_t req_size,
   input  mem_pkg::dest_t      req_src,
   input  mem_pkg::line_t      req_line,
   output mem_pkg::mem_addr_t  acc_addr,
   output mem_pkg::size_code_t acc_size,
   output mem_pkg::line_t      acc_line,
   output logic                mem_en,
   output logic                mem_wr,
   output mem_pkg::row_idx_t   mem_row,
   input  mem_pkg::row_t       rd_row,
   output logic                ret_valid,
   input  logic                ret_ready,
   output mem_pkg::bus_addr_t  ret_addr,
   output mem_pkg::dest_t      ret_src,
   output mem_pkg::line_t      ret_line
);
   import mem_pkg::*;

   // Write latch stage
   logic          wl_valid;
   logic          wl_write;
   bus_addr_t     wl_addr;
   size_code_t    wl_size;
   dest_t         wl_src;
   line_t         wl_line;

   // Access stage
   logic          ac_valid;
   logic          ac_write;
   bus_addr_t     ac_addr;
   size_code_t    ac_size;
   dest_t         ac_src;
   line_t         ac_line;

   logic [7:0]    timer;
   access_state_t phase;
   logic          at_strobe;
   logic          rd_capture;
   logic          ld_wl;
   logic          ld_ac;
   logic          clr_ac;

   //////////////////////////////
   // Stage load and clear
   //////////////////////////////
   assign clr_ac    = (phase == ACC_DONE) & (ac_write | ret_ready);
   assign ld_ac     = wl_valid & (~ac_valid | clr_ac);
   assign req_ready = ~wl_valid | ld_ac;
   assign ld_wl     = req_valid & req_ready;

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wl_valid <= 1'b0;
         ac_valid <= 1'b0;
         timer    <= '0;
      end
      else
      begin
         if (ld_wl)
            wl_valid <= 1'b1;
         else if (ld_ac)
            wl_valid <= 1'b0;

         if (ld_ac)
            ac_valid <= 1'b1;
         else if (clr_ac)
            ac_valid <= 1'b0;

         // One more bit set each cycle, restarts on a new access
         if (ld_ac)
            timer <= 8'b0000_0001;
         else if (ac_valid)
            timer <= {timer[6:0], 1'b1};
      end
   end

   always_ff @(posedge bus_clk)
   begin
      if (ld_wl)
      begin
         wl_write <= req_write;
         wl_addr  <= req_addr;
         wl_size  <= req_size;
         wl_src   <= req_src;
         wl_line  <= req_line;
      end
      if (ld_ac)
      begin
         ac_write <= wl_write;
         ac_addr  <= wl_addr;
         ac_size  <= wl_size;
         ac_src   <= wl_src;
         ac_line  <= wl_line;
      end
      // Half row picked by address bit 4
      if (rd_capture)
         ret_line <= ac_addr[4] ? rd_row[255:128] : rd_row[127:0];
   end

   //////////////////////////////
   // Timer decode
   //////////////////////////////
   assign at_strobe = ac_write ?
                      (timer[WRITE_STROBE_STEP] & ~timer[WRITE_STROBE_STEP + 1]) :
                      (timer[READ_SAMPLE_STEP] & ~timer[READ_SAMPLE_STEP + 1]);

   always_comb
   begin
      if (!ac_valid)
         phase = ACC_IDLE;
      else if (timer[DONE_STEP])
         phase = ACC_DONE;
      else if (at_strobe)
         phase = ACC_STROBE;
      else
         phase = ACC_WAIT;
   end

   // Array data is out one cycle after the read strobe
   assign rd_capture = ac_valid & ~ac_write &
                       timer[READ_SAMPLE_STEP + 1] & ~timer[READ_SAMPLE_STEP + 2];

   assign mem_en   = (phase == ACC_STROBE);
   assign mem_wr   = mem_en & ac_write;
   assign mem_row  = ac_addr[14:5];
   assign acc_addr = ac_addr[14:0];
   assign acc_size = ac_size;
   assign acc_line = ac_line;

   assign ret_valid = (phase == ACC_DONE) & ~ac_write;
   assign ret_addr  = ac_addr;
   assign ret_src   = ac_src;

endmodule

`default_nettype wire

// ==== rtl/mem_write_align.sv ====
//////////////////////////////
// Write aligner: places the payload in a row
// and builds the byte enables
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module mem_write_align
(
   input  mem_pkg::mem_addr_t  acc_addr,
   input  mem_pkg::size_code_t acc_size,
   input  mem_pkg::line_t      acc_line,
   output mem_pkg::row_t       wr_row,
   output mem_pkg::byte_mask_t wr_mask
);
   import mem_pkg::*;

   logic [4:0] byte_off;
   logic [7:0] bit_off;
   logic [5:0] n_bytes;
   byte_mask_t size_mask;
   row_t       wide_line;

   // Byte position inside the 32-byte row, half row included
   assign byte_off = acc_addr[4:0];
   assign bit_off  = {byte_off, 3'b000};

   //////////////////////////////
   // Data shifter
   //////////////////////////////
   // Upper half starts as zero, payload byte 0 lands on byte_off
   assign wide_line = row_t'(acc_line);
   assign wr_row    = wide_line << bit_off;

   //////////////////////////////
   // Byte mask
   //////////////////////////////
   // 2^size low ones, moved to the same offset as the data
   assign n_bytes   = 6'd1 << acc_size;
   assign size_mask = (byte_mask_t'(1) << n_bytes) - byte_mask_t'(1);
   assign wr_mask   = size_mask << byte_off;

endmodule

`default_nettype wire

// ==== rtl/mem_array.sv ====
//////////////////////////////
// Memory array: 1024 x 256-bit rows
// with byte writes and a registered read
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module mem_array
(
   input  logic                bus_clk,
   input  logic                mem_en,
   input  logic                mem_wr,
   input  mem_pkg::row_idx_t   mem_row,
   input  mem_pkg::row_t       wr_row,
   input  mem_pkg::byte_mask_t wr_mask,
   output mem_pkg::row_t       rd_row
);
   import mem_pkg::*;

   localparam int NUM_ROWS  = 2 ** $bits(row_idx_t);
   localparam int ROW_BYTES = $bits(byte_mask_t);

   row_t mem [NUM_ROWS];

   //////////////////////////////
   // Write port
   //////////////////////////////
   // Only bytes with their enable set change
   always_ff @(posedge bus_clk)
   begin
      if (mem_en && mem_wr)
      begin
         for (int b = 0; b < ROW_BYTES; b++)
         begin
            if (wr_mask[b])
               mem[mem_row][8*b +: 8] <= wr_row[8*b +: 8];
         end
      end
   end

   //////////////////////////////
   // Read port
   //////////////////////////////
   // Whole row out on the cycle after the strobe
   always_ff @(posedge bus_clk)
   begin
      if (mem_en && !mem_wr)
         rd_row <= mem[mem_row];
   end

endmodule

`default_nettype wire

// ==== rtl/bus_master_port.sv ====
//////////////////////////////
// Bus master port: requests the bus and
// returns a read line as four beats
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module bus_master_port
(
   input  logic               bus_clk,
   input  logic               arst_n,
   input  logic               ret_valid,
   output logic               ret_ready,
   input  mem_pkg::bus_addr_t ret_addr,
   input  mem_pkg::dest_t     ret_src,
   input  mem_pkg::line_t     ret_line,
   output logic               br,
   input  logic               bg,
   output logic               out_valid,
   input  logic               out_ready,
   output mem_pkg::bus_addr_t out_addr,
   output mem_pkg::dest_t     out_dest,
   output mem_pkg::bus_word_t out_data
);
   import mem_pkg::*;

   logic      held;
   beat_idx_t beat;
   bus_addr_t line_addr;
   dest_t     line_dest;
   line_t     line_buf;
   logic      ret_xfer;
   logic      out_xfer;
   logic      last_beat;

   // One line at a time, next one waits in the access stage
   assign ret_ready = ~held;
   assign ret_xfer  = ret_valid & ret_ready;
   assign out_xfer  = out_valid & out_ready;
   assign last_beat = (beat == beat_idx_t'(BEATS_PER_LINE - 1));

   //////////////////////////////
   // Request, grant and beat control
   //////////////////////////////
   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         held      <= 1'b0;
         br        <= 1'b0;
         out_valid <= 1'b0;
         beat      <= '0;
      end
      else if (ret_xfer)
      begin
         held <= 1'b1;
         br   <= 1'b1;
      end
      else if (held && bg && !out_valid)
      begin
         // Grant seen, first beat goes out
         out_valid <= 1'b1;
      end
      else if (out_xfer)
      begin
         beat <= beat + beat_idx_t'(1);
         if (last_beat)
         begin
            out_valid <= 1'b0;
            br        <= 1'b0;
            held      <= 1'b0;
         end
      end
   end

   always_ff @(posedge bus_clk)
   begin
      if (ret_xfer)
      begin
         line_addr <= ret_addr;
         line_dest <= ret_src;
         line_buf  <= ret_line;
      end
   end

   // Lowest word first
   assign out_data = line_buf[32*beat +: 32];
   assign out_addr = {line_addr[15:4], 4'b0000};
   assign out_dest = line_dest;

endmodule

`default_nettype wire

// ==== rtl/mem_subsystem.sv ====
//////////////////////////////
// Memory subsystem top: bus ports,
// access controller, aligner and array
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem
(
   input  logic                bus_clk,
   input  logic                arst_n,
   input  logic                in_valid,
   output logic                in_ready,
   input  logic                in_write,
   input  mem_pkg::bus_addr_t  in_addr,
   input  mem_pkg::size_code_t in_size,
   input  mem_pkg::dest_t      in_src,
   input  mem_pkg::bus_word_t  in_data,
   output logic                br,
   input  logic                bg,
   output logic                out_valid,
   input  logic                out_ready,
   output mem_pkg::bus_addr_t  out_addr,
   output mem_pkg::dest_t      out_dest,
   output mem_pkg::bus_word_t  out_data
);
   import mem_pkg::*;

   // Slave port to controller
   logic       req_valid;
   logic       req_ready;
   logic       req_write;
   bus_addr_t  req_addr;
   size_code_t req_size;
   dest_t      req_src;
   line_t      req_line;

   // Controller, aligner and array
   mem_addr_t  acc_addr;
   size_code_t acc_size;
   line_t      acc_line;
   row_t       wr_row;
   byte_mask_t wr_mask;
   logic       mem_en;
   logic       mem_wr;
   row_idx_t   mem_row;
   row_t       rd_row;

   // Controller to master port
   logic       ret_valid;
   logic       ret_ready;
   bus_addr_t  ret_addr;
   dest_t      ret_src;
   line_t      ret_line;

   bus_slave_port u_slave
   (
      .bus_clk(bus_clk), .arst_n(arst_n),
      .in_valid(in_valid), .in_ready(in_ready), .in_write(in_write),
      .in_addr(in_addr), .in_size(in_size), .in_src(in_src), .in_data(in_data),
      .req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
      .req_addr(req_addr), .req_size(req_size), .req_src(req_src),
      .req_line(req_line)
   );

   mem_access_ctrl u_ctrl
   (
      .bus_clk(bus_clk), .arst_n(arst_n),
      .req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
      .req_addr(req_addr), .req_size(req_size), .req_src(req_src),
      .req_line(req_line),
      .acc_addr(acc_addr), .acc_size(acc_size), .acc_line(acc_line),
      .mem_en(mem_en), .mem_wr(mem_wr), .mem_row(mem_row), .rd_row(rd_row),
      .ret_valid(ret_valid), .ret_ready(ret_ready), .ret_addr(ret_addr),
      .ret_src(ret_src), .ret_line(ret_line)
   );

   mem_write_align u_align
   (
      .acc_addr(acc_addr), .acc_size(acc_size), .acc_line(acc_line),
      .wr_row(wr_row), .wr_mask(wr_mask)
   );

   mem_array u_array
   (
      .bus_clk(bus_clk), .mem_en(mem_en), .mem_wr(mem_wr), .mem_row(mem_row),
      .wr_row(wr_row), .wr_mask(wr_mask), .rd_row(rd_row)
   );

   bus_master_port u_master
   (
      .bus_clk(bus_clk), .arst_n(arst_n),
      .ret_valid(ret_valid), .ret_ready(ret_ready), .ret_addr(ret_addr),
      .ret_src(ret_src), .ret_line(ret_line),
      .br(br), .bg(bg),
      .out_valid(out_valid), .out_ready(out_ready), .out_addr(out_addr),
      .out_dest(out_dest), .out_data(out_data)
   );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
//////////////////////////////
// Testbench clock and reset
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
(
   output logic bus_clk,
   output logic arst_n
);

   // 10 ns bus clock
   initial
   begin
      bus_clk = 1'b0;
      forever #5 bus_clk = ~bus_clk;
   end

   // Reset held for 8 cycles, released on a falling edge
   initial
   begin
      arst_n = 1'b0;
      repeat (8) @(posedge bus_clk);
      @(negedge bus_clk);
      arst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== test/tb_mem_subsystem.sv ====
//////////////////////////////
// Memory subsystem testbench: directed tests
// against a byte model of the memory
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsystem;
   import mem_pkg::*;

   localparam int    WAIT_LIMIT = 2000;
   localparam dest_t SRC_IC     = 3'b001;
   localparam dest_t SRC_DC     = 3'b010;
   localparam dest_t SRC_DMA    = 3'b100;

   logic       bus_clk;
   logic       arst_n;
   logic       in_valid;
   logic       in_ready;
   logic       in_write;
   bus_addr_t  in_addr;
   size_code_t in_size;
   dest_t      in_src;
   bus_word_t  in_data;
   logic       br;
   logic       bg;
   logic       out_valid;
   logic       out_ready;
   bus_addr_t  out_addr;
   dest_t      out_dest;
   bus_word_t  out_data;

   // Reference memory and lines expected back, in issue order
   logic [7:0] ref_mem [0:32767];
   line_t      exp_lines [$];
   bus_addr_t  exp_addrs [$];
   dest_t      exp_dests [$];

   logic [15:0] lfsr_state = 16'd33;
   int          checks;
   int          errors;
   int          max_in_wait;

   tb_clock_gen u_clk
   (
      .bus_clk(bus_clk),
      .arst_n(arst_n)
   );

   mem_subsystem dut
   (
      .bus_clk(bus_clk), .arst_n(arst_n),
      .in_valid(in_valid), .in_ready(in_ready), .in_write(in_write),
      .in_addr(in_addr), .in_size(in_size), .in_src(in_src), .in_data(in_data),
      .br(br), .bg(bg),
      .out_valid(out_valid), .out_ready(out_ready), .out_addr(out_addr),
      .out_dest(out_dest), .out_data(out_data)
   );

   //////////////////////////////
   // Stimulus helpers
   //////////////////////////////
   // Galois LFSR x^16+x^14+x^13+x^11+1, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      logic        lsb;
      int          i;
      v = '0;
      for (i = 0; i < n; i++)
      begin
         lsb        = lfsr_state[0];
         lfsr_state = lfsr_state >> 1;
         if (lsb)
            lfsr_state = lfsr_state ^ 16'hB400;
         v = {v[30:0], lsb};
      end
      return v;
   endfunction

   function automatic line_t random_line();
      line_t d;
      int    k;
      for (k = 0; k < 4; k++)
         d[32*k +: 32] = take_bits(32);
      return d;
   endfunction

   // Whole aligned line as the model holds it
   function automatic line_t model_line(input bus_addr_t a);
      line_t d;
      int    base;
      int    b;
      base = {a[14:4], 4'h0};
      for (b = 0; b < 16; b++)
         d[8*b +: 8] = ref_mem[base + b];
      return d;
   endfunction

   task automatic model_write(input bus_addr_t a, input size_code_t s, input line_t d);
      int idx;
      int k;
      idx = a[14:0];
      for (k = 0; k < (1 << s); k++)
         ref_mem[idx + k] = d[8*k +: 8];
   endtask

   //////////////////////////////
   // Compare tasks
   //////////////////////////////
   task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input bus_addr_t got, input bus_addr_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_dest(input string name, input dest_t got, input dest_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   //////////////////////////////
   // Bus tasks
   //////////////////////////////
   // Starts and ends on a falling edge
   task automatic drive_beat(input logic wr, input bus_addr_t a, input size_code_t s,
                             input dest_t src, input bus_word_t d);
      int waited;
      in_valid = 1'b1;
      in_write = wr;
      in_addr  = a;
      in_size  = s;
      in_src   = src;
      in_data  = d;
      waited   = 0;
      while (!in_ready && waited < WAIT_LIMIT)
      begin
         @(negedge bus_clk);
         waited++;
      end
      if (waited > max_in_wait)
         max_in_wait = waited;
      if (!in_ready)
      begin
         errors++;
         $display("in_ready stayed low, request beat was never taken");
         in_valid = 1'b0;
         return;
      end
      @(posedge bus_clk);
      @(negedge bus_clk);
      in_valid = 1'b0;
   endtask

   task automatic send_write(input bus_addr_t a, input size_code_t s, input dest_t src,
                             input line_t d);
      int k;
      model_write(a, s, d);
      for (k = 0; k < 4; k++)
         drive_beat(1'b1, a, s, src, d[32*k +: 32]);
   endtask

   task automatic send_read(input bus_addr_t a, input dest_t src);
      exp_lines.push_back(model_line(a));
      exp_addrs.push_back({a[15:4], 4'h0});
      exp_dests.push_back(src);
      drive_beat(1'b0, a, 3'd0, src, 32'h0);
   endtask

   // Plays the arbiter and the receiving cache for one line
   task automatic collect_line(input int grant_delay, input logic stall);
      line_t     line;
      bus_addr_t a;
      dest_t     d;
      int        waited;
      int        k;
      logic      sent;
      bg     = 1'b0;
      waited = 0;
      while (!br && waited < WAIT_LIMIT)
      begin
         @(negedge bus_clk);
         waited++;
      end
      if (!br)
      begin
         errors++;
         $display("bus request never rose for an expected line");
         return;
      end
      // Expected entries are queued before the read beat goes out
      if (exp_lines.size() == 0)
      begin
         errors++;
         $display("a line came back with none expected");
         return;
      end
      line = exp_lines.pop_front();
      a    = exp_addrs.pop_front();
      d    = exp_dests.pop_front();
      repeat (grant_delay) @(negedge bus_clk);
      bg = 1'b1;
      for (k = 0; k < 4; k++)
      begin
         sent   = 1'b0;
         waited = 0;
         while (!sent && waited < WAIT_LIMIT)
         begin
            @(negedge bus_clk);
            out_ready = stall ? (take_bits(1) != 32'd0) : 1'b1;
            if (out_valid && out_ready)
            begin
               check_word("out_data", out_data, line[32*k +: 32]);
               check_addr("out_addr", out_addr, a);
               check_dest("out_dest", out_dest, d);
               sent = 1'b1;
            end
            waited++;
         end
         if (!sent)
         begin
            errors++;
            $display("return beat %0d never arrived", k);
            bg = 1'b0;
            return;
         end
      end
      @(negedge bus_clk);
      bg        = 1'b0;
      out_ready = 1'b1;
   endtask

   // Bus stays quiet and nothing is left outstanding
   task automatic check_idle(input int cycles);
      repeat (cycles)
      begin
         @(negedge bus_clk);
         check_flag("br", br, 1'b0);
         check_flag("out_valid", out_valid, 1'b0);
         check_flag("in_ready", in_ready, 1'b1);
      end
      if (exp_lines.size() != 0)
      begin
         errors++;
         $display("%0d expected lines never came back", exp_lines.size());
         exp_lines.delete();
         exp_addrs.delete();
         exp_dests.delete();
      end
   endtask

   task automatic end_test(input string name, input int start);
      $display("%-16s %s (%0d errors)", name, (errors == start) ? "ok" : "failed",
               errors - start);
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////
   task automatic test_reset();
      int start;
      int waited;
      start  = errors;
      waited = 0;
      while (!arst_n && waited < WAIT_LIMIT)
      begin
         @(negedge bus_clk);
         waited++;
         check_flag("in_ready", in_ready, 1'b1);
         check_flag("br", br, 1'b0);
         check_flag("out_valid", out_valid, 1'b0);
      end
      if (!arst_n)
      begin
         errors++;
         $display("reset was never released");
      end
      check_idle(20);
      end_test("reset state", start);
   endtask

   task automatic test_full_line();
      int start;
      start = errors;
      send_write(16'h0120, 3'd4, SRC_DMA, random_line());
      // Offset inside the line, returned address is still aligned
      send_read(16'h0124, SRC_DC);
      collect_line(0, 1'b0);
      check_idle(5);
      end_test("full line", start);
   endtask

   task automatic test_partial();
      int start;
      start = errors;
      send_write(16'h0200, 3'd4, SRC_DC, random_line());
      send_write(16'h0210, 3'd4, SRC_DC, random_line());
      // Lower half row
      send_write(16'h0201, 3'd0, SRC_DC, random_line());
      send_write(16'h0202, 3'd1, SRC_DC, random_line());
      send_write(16'h0204, 3'd2, SRC_DC, random_line());
      send_write(16'h0208, 3'd3, SRC_DC, random_line());
      // Upper half row, byte 12 left alone
      send_write(16'h021F, 3'd0, SRC_DMA, random_line());
      send_write(16'h021D, 3'd1, SRC_DMA, random_line());
      send_write(16'h0218, 3'd2, SRC_DMA, random_line());
      send_write(16'h0210, 3'd3, SRC_DMA, random_line());
      send_read(16'h0200, SRC_DC);
      collect_line(0, 1'b0);
      send_read(16'h0210, SRC_DMA);
      collect_line(0, 1'b0);
      check_idle(5);
      end_test("partial writes", start);
   endtask

   task automatic test_ordering();
      int         start;
      int         i;
      bus_addr_t  ln;
      bus_addr_t  off;
      size_code_t s;
      start = errors;
      for (i = 0; i < 4; i++)
         send_write(bus_addr_t'(16'h0400 + 16 * i), 3'd4, SRC_DC, random_line());
      fork
         begin
            for (i = 0; i < 8; i++)
            begin
               ln  = bus_addr_t'(16'h0400 + (take_bits(2) << 4));
               s   = size_code_t'(take_bits(2));
               off = bus_addr_t'(take_bits(4)) & ~((bus_addr_t'(1) << s) - bus_addr_t'(1));
               send_write(ln | off, s, SRC_DC, random_line());
               // Even steps read the line just written
               if (i % 2 == 0)
                  send_read(ln, SRC_DC);
               else
                  send_read(bus_addr_t'(16'h0400 + (take_bits(2) << 4)), SRC_IC);
            end
         end
         begin
            repeat (8) collect_line(0, 1'b0);
         end
      join
      check_idle(20);
      end_test("ordering", start);
   endtask

   task automatic test_backpressure();
      int        start;
      int        i;
      bus_addr_t addrs [6];
      start = errors;
      for (i = 0; i < 4; i++)
         send_write(bus_addr_t'(16'h0600 + 16 * i), 3'd4, SRC_DMA, random_line());
      for (i = 0; i < 6; i++)
         addrs[i] = bus_addr_t'(16'h0600 + 16 * ((i * 3) % 4) + 4 * (i % 4));
      max_in_wait = 0;
      fork
         begin
            for (i = 0; i < 6; i++)
               send_read(addrs[i], SRC_DC);
         end
         begin
            // Long grant delay first, so the inbound side fills up
            collect_line(40, 1'b1);
            repeat (5) collect_line(take_bits(3), 1'b1);
         end
      join
      if (max_in_wait < 20)
      begin
         errors++;
         $display("in_ready never held the bus off while the output was stalled");
      end
      check_idle(20);
      end_test("back-pressure", start);
   endtask

   task automatic test_routing();
      int start;
      start = errors;
      send_write(16'h0700, 3'd4, SRC_DMA, random_line());
      send_read(16'h0700, SRC_IC);
      collect_line(0, 1'b0);
      send_read(16'h0708, SRC_DC);
      collect_line(2, 1'b0);
      send_read(16'h070C, SRC_DMA);
      collect_line(0, 1'b0);
      check_idle(5);
      end_test("routing", start);
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////
   initial
   begin
      in_valid    = 1'b0;
      in_write    = 1'b0;
      in_addr     = '0;
      in_size     = '0;
      in_src      = '0;
      in_data     = '0;
      bg          = 1'b0;
      out_ready   = 1'b1;
      checks      = 0;
      errors      = 0;
      max_in_wait = 0;
      test_reset();
      test_full_line();
      test_partial();
      test_ordering();
      test_backpressure();
      test_routing();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

   // Cycle limit for the whole run
   initial
   begin
      repeat (200000) @(posedge bus_clk);
      $display("simulation ran past its cycle limit");
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/mem_pkg.sv
rtl/bus_slave_port.sv
rtl/mem_access_ctrl.sv
rtl/mem_write_align.sv
rtl/mem_array.sv
rtl/bus_master_port.sv
rtl/mem_subsystem.sv
test/tb_clock_gen.sv
test/tb_mem_subsystem.sv
